//--- ldq.f
+incdir+include
src/ldq_core_pkg.sv
src/ldq_lsu_pkg.sv
src/ldq_wakeup_match.sv
src/ldq_entry.sv
src/ldq_ptr_ctrl.sv
src/ldq_issue_sel.sv
src/ldq_top.sv
verification/tb_ldq.sv

//--- Bender.yml
package:
  name: ldq

export_include_dirs:
  - include

sources:
  - files:
      - src/ldq_core_pkg.sv
      - src/ldq_lsu_pkg.sv
      - src/ldq_wakeup_match.sv
      - src/ldq_entry.sv
      - src/ldq_ptr_ctrl.sv
      - src/ldq_issue_sel.sv
      - src/ldq_top.sv
  - target: test
    files:
      - verification/tb_ldq.sv

//--- verification/tb_ldq.sv
`include "ldq_cfg.svh"

module tb_ldq;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 4;
  localparam int TEST_LEN_SUM = 220;  // cycles over all five tests
  localparam int ISSUE_WAIT   = 20;

  logic clk;
  logic reset_n;
  logic disp_valid;
  logic disp_ready;
  logic issue_valid;
  logic ex1_valid;
  logic ex2_valid;
  logic tlb_resolve;
  logic flush;
  ldq_core_pkg::disp_t        disp;
  ldq_core_pkg::phy_wr_t      phy_wr [`WB_BUS_SIZE];
  ldq_core_pkg::commit_t      commit;
  ldq_lsu_pkg::issue_t        issue;
  ldq_lsu_pkg::ex1_update_t   ex1_update;
  ldq_lsu_pkg::ex2_update_t   ex2_update;
  ldq_lsu_pkg::lrq_resolve_t  lrq_resolve;
  ldq_lsu_pkg::stq_resolve_t  stq_resolve;

  // expectation state read by the assertions
  string                 test_name;
  logic                  order_on;
  logic                  no_issue;
  logic                  full_on;
  logic                  wake_on;
  logic [`CMT_ID_W-1:0]  exp_cmt;
  logic [`LDQ_IDX_W-1:0] exp_idx;
  logic [`RNID_W-1:0]    wake_tag;
  logic [`CMT_ID_W-1:0]  wake_cmt;
  logic [`CMT_ID_W-1:0]  sb [$];  // dispatched cmt_ids in age order
  int                    errors;
  int                    tests_run;
  int                    tests_failed;
  int                    err_at_start;
  logic [31:0]           rng;

  ldq_top i_ldq_top (
    .i_clk         (clk),
    .i_reset_n     (reset_n),
    .i_disp_valid  (disp_valid),
    .i_disp        (disp),
    .o_disp_ready  (disp_ready),
    .i_phy_wr      (phy_wr),
    .o_issue_valid (issue_valid),
    .o_issue       (issue),
    .i_ex1_valid   (ex1_valid),
    .i_ex1_update  (ex1_update),
    .i_ex2_valid   (ex2_valid),
    .i_ex2_update  (ex2_update),
    .i_tlb_resolve (tlb_resolve),
    .i_lrq_resolve (lrq_resolve),
    .i_stq_resolve (stq_resolve),
    .i_commit      (commit),
    .i_flush       (flush)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  a_issue_order: assert property (@(posedge clk) disable iff (!reset_n)
    order_on & issue_valid |-> (issue.cmt_id == exp_cmt) && (issue.index == exp_idx))
    else begin
      errors++;
      $display("Error %s: expected cmt_id %0d index %0d, actual cmt_id %0d index %0d",
               test_name, exp_cmt, exp_idx, $sampled(issue.cmt_id), $sampled(issue.index));
    end

  a_hold_issue: assert property (@(posedge clk) disable iff (!reset_n)
    no_issue |-> !issue_valid)
    else begin
      errors++;
      $display("%s: a load issued while it should still be waiting", test_name);
    end

  a_full: assert property (@(posedge clk) disable iff (!reset_n) full_on |-> !disp_ready)
    else begin
      errors++;
      $display("Error %s: expected o_disp_ready 0, actual 1", test_name);
    end

  a_commit_free: assert property (@(posedge clk) disable iff (!reset_n)
    commit.commit & !disp_ready |=> disp_ready)
    else begin
      errors++;
      $display("Error %s: expected o_disp_ready 1 after commit, actual 0", test_name);
    end

  a_flush_empty: assert property (@(posedge clk) disable iff (!reset_n)
    flush |=> !issue_valid && disp_ready)
    else begin
      errors++;
      $display("%s: queue still busy in the cycle after a flush", test_name);
    end

  a_wakeup: assert property (@(posedge clk) disable iff (!reset_n)
    wake_on & phy_wr[1].valid & (phy_wr[1].rd_rnid == wake_tag)
    |=> issue_valid && (issue.cmt_id == wake_cmt))
    else begin
      errors++;
      $display("Error %s: expected issue of cmt_id %0d, actual valid %0b cmt_id %0d",
               test_name, wake_cmt, $sampled(issue_valid), $sampled(issue.cmt_id));
    end

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic ldq_core_pkg::disp_t make_load(logic [`CMT_ID_W-1:0] cmt,
                                                     logic rdy, logic [`RNID_W-1:0] tag);
    ldq_core_pkg::disp_t d;
    d = '0;
    d.cmt_id    = cmt;
    d.rs1_valid = 1'b1;
    d.rs1_rnid  = tag;
    d.rs1_ready = rdy;
    return d;
  endfunction

  // strobes drop after each edge unless driven again
  task automatic step();
    @(posedge clk);
    disp_valid        <= 1'b0;
    phy_wr[0].valid   <= 1'b0;
    phy_wr[1].valid   <= 1'b0;
    ex1_valid         <= 1'b0;
    ex2_valid         <= 1'b0;
    tlb_resolve       <= 1'b0;
    lrq_resolve.valid <= 1'b0;
    stq_resolve.valid <= 1'b0;
    commit.commit     <= 1'b0;
    flush             <= 1'b0;
  endtask

  task automatic next_rand(output logic [31:0] r);
    rng = xorshift(rng);
    r = rng;
  endtask

  task automatic dispatch(logic [`CMT_ID_W-1:0] cmt, logic rdy, logic [`RNID_W-1:0] tag);
    step();
    disp_valid <= 1'b1;
    disp       <= make_load(cmt, rdy, tag);
    sb.push_back(cmt);
  endtask

  task automatic wait_issue();
    int n;
    n = 0;
    do begin
      step();
      n++;
    end while (!issue_valid && n < ISSUE_WAIT);
    if (!issue_valid) begin
      errors++;
      $display("%s: no load issued within %0d cycles", test_name, ISSUE_WAIT);
    end
  endtask

  task automatic drive_ex1(logic haz);
    ex1_valid             <= 1'b1;
    ex1_update.index      <= exp_idx;
    ex1_update.tlb_hazard <= haz;
    ex1_update.tlb_except <= 1'b0;
    ex1_update.paddr      <= rng[`PADDR_W-1:0];
  endtask

  task automatic drive_ex2(ldq_lsu_pkg::hazard_t typ, logic [3:0] lrq_oh, logic [3:0] stq_oh);
    ex2_valid               <= 1'b1;
    ex2_update.index        <= exp_idx;
    ex2_update.hazard_typ   <= typ;
    ex2_update.lrq_index_oh <= lrq_oh;
    ex2_update.stq_haz_oh   <= stq_oh;
  endtask

  task automatic flush_queue();
    step();
    flush <= 1'b1;
    step();
    sb.delete();
  endtask

  task automatic start_test(string name);
    test_name    = name;
    err_at_start = errors;
    tests_run++;
  endtask

  task automatic end_test();
    order_on = 1'b0;
    no_issue = 1'b0;
    if (errors == err_at_start) begin
      $display("test %s passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", test_name, errors - err_at_start);
    end
  endtask

  task automatic fill_and_free();
    logic [31:0] r;
    start_test("capacity");
    next_rand(r);
    dispatch(r[5:0], 1'b1, 5'd1);  // ready head load
    for (int i = 1; i < `LDQ_SIZE; i++) begin
      dispatch(r[5:0] + i, 1'b0, 5'd30);
    end
    exp_idx = '0;
    step();
    full_on = 1'b1;
    drive_ex1(1'b0);
    step();
    drive_ex2(ldq_lsu_pkg::HAZ_NONE, 4'b0, 4'b0);
    step();
    step();
    full_on = 1'b0;
    commit.commit <= 1'b1;
    commit.cmt_id <= sb[0];
    step();
    step();
    end_test();
  endtask

  task automatic wakeup_on_writeback();
    logic [31:0] r;
    start_test("wakeup");
    flush_queue();
    next_rand(r);
    dispatch(r[5:0], 1'b0, r[12:8]);
    no_issue = 1'b1;
    repeat (2 + r[17:16]) step();
    step();
    no_issue          = 1'b0;
    wake_on           = 1'b1;
    wake_tag          = r[12:8];
    wake_cmt          = r[5:0];
    phy_wr[1].valid   <= 1'b1;
    phy_wr[1].rd_rnid <= r[12:8];
    wait_issue();
    wake_on = 1'b0;
    end_test();
  endtask

  task automatic issue_oldest_first();
    logic [31:0] r;
    start_test("age_order");
    flush_queue();
    next_rand(r);
    no_issue = 1'b1;
    for (int i = 0; i < 3; i++) begin
      dispatch(r[5:0] + 7 * i, 1'b0, r[20:16]);
    end
    step();
    no_issue = 1'b0;
    phy_wr[0].valid   <= 1'b1;
    phy_wr[0].rd_rnid <= r[20:16];
    order_on = 1'b1;
    for (int i = 0; i < 3; i++) begin
      exp_cmt = sb.pop_front();
      exp_idx = i;
      wait_issue();
    end
    end_test();
  endtask

  task automatic replay_after_hazards();
    logic [31:0] r;
    start_test("replay");
    flush_queue();
    next_rand(r);
    dispatch(r[5:0], 1'b1, 5'd2);
    order_on = 1'b1;
    exp_cmt  = r[5:0];
    exp_idx  = '0;
    wait_issue();
    drive_ex1(1'b0);
    step();
    drive_ex2(ldq_lsu_pkg::HAZ_STQ_DEPEND, 4'b0, 4'b0101);
    no_issue = 1'b1;
    step();
    stq_resolve <= '{valid: 1'b1, resolve_oh: 4'b0001};
    repeat (3) step();
    no_issue = 1'b0;
    stq_resolve <= '{valid: 1'b1, resolve_oh: 4'b0100};
    wait_issue();
    drive_ex1(1'b0);
    step();
    drive_ex2(ldq_lsu_pkg::HAZ_LRQ_CONFLICT, 4'b0010, 4'b0);
    no_issue = 1'b1;
    step();
    lrq_resolve <= '{valid: 1'b1, resolve_oh: 4'b0100};  // other slot
    repeat (2) step();
    no_issue = 1'b0;
    lrq_resolve <= '{valid: 1'b1, resolve_oh: 4'b0010};
    wait_issue();
    drive_ex1(1'b1);
    no_issue = 1'b1;
    repeat (3) step();
    no_issue = 1'b0;
    tlb_resolve <= 1'b1;
    wait_issue();
    drive_ex1(1'b0);
    step();
    drive_ex2(ldq_lsu_pkg::HAZ_NONE, 4'b0, 4'b0);
    step();
    step();
    commit.commit <= 1'b1;
    commit.cmt_id <= exp_cmt;
    step();
    end_test();
  endtask

  task automatic flush_and_refill();
    logic [31:0] r;
    start_test("flush");
    next_rand(r);
    for (int i = 0; i < `LDQ_SIZE - 1; i++) begin
      dispatch(r[5:0] + i, 1'b1, 5'd3);
    end
    step();
    flush <= 1'b1;
    disp_valid <= 1'b1;  // flush wins over this dispatch into the last free slot
    step();
    sb.delete();
    order_on = 1'b1;
    for (int i = 0; i < 2; i++) begin
      dispatch(r[13:8] + i, 1'b1, 5'd4);
      exp_cmt = sb.pop_front();
      exp_idx = i;
      wait_issue();
    end
    end_test();
  endtask

  initial begin
    #(TEST_LEN_SUM * 2 * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    clk = 1'b0;
    reset_n = 1'b0;
    disp_valid = 1'b0;
    disp = '0;
    for (int p = 0; p < `WB_BUS_SIZE; p++) begin
      phy_wr[p] = '0;
    end
    ex1_valid = 1'b0;
    ex1_update = '0;
    ex2_valid = 1'b0;
    ex2_update = '0;
    tlb_resolve = 1'b0;
    lrq_resolve = '0;
    stq_resolve = '0;
    commit = '0;
    flush = 1'b0;
    order_on = 1'b0;
    no_issue = 1'b0;
    full_on = 1'b0;
    wake_on = 1'b0;
    exp_cmt = '0;
    exp_idx = '0;
    wake_tag = '0;
    wake_cmt = '0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    rng = 32'd77;
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;
    fill_and_free();
    wakeup_on_writeback();
    issue_oldest_first();
    replay_after_hazards();
    flush_and_refill();
    step();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- src/ldq_top.sv
`include "ldq_cfg.svh"

module ldq_top (
  input  logic                       i_clk,
  input  logic                       i_reset_n,

  input  logic                       i_disp_valid,
  input  ldq_core_pkg::disp_t        i_disp,
  output logic                       o_disp_ready,

  input  ldq_core_pkg::phy_wr_t      i_phy_wr [`WB_BUS_SIZE],

  output logic                       o_issue_valid,
  output ldq_lsu_pkg::issue_t        o_issue,

  input  logic                       i_ex1_valid,
  input  ldq_lsu_pkg::ex1_update_t   i_ex1_update,
  input  logic                       i_ex2_valid,
  input  ldq_lsu_pkg::ex2_update_t   i_ex2_update,

  input  logic                       i_tlb_resolve,
  input  ldq_lsu_pkg::lrq_resolve_t  i_lrq_resolve,
  input  ldq_lsu_pkg::stq_resolve_t  i_stq_resolve,

  input  ldq_core_pkg::commit_t      i_commit,
  input  logic                       i_flush
);

  logic [`LDQ_IDX_W-1:0]   w_tail;
  logic [`LDQ_IDX_W-1:0]   w_head;
  logic [`LDQ_SIZE-1:0]    w_load;
  logic [`LDQ_SIZE-1:0]    w_picked;
  logic [`LDQ_SIZE-1:0]    w_finish;
  logic                    w_ready [`LDQ_SIZE];
  ldq_lsu_pkg::ldq_entry_t w_entries [`LDQ_SIZE];

  // tail slot takes the dispatched load
  assign w_load = i_disp_valid ? (`LDQ_SIZE'(1) << w_tail) : '0;

  for (genvar e = 0; e < `LDQ_SIZE; e++) begin : g_entry
    ldq_entry #(
      .ENTRY_IDX (e)
    ) u_entry (
      .i_clk         (i_clk),
      .i_reset_n     (i_reset_n),
      .i_load        (w_load[e]),
      .i_disp        (i_disp),
      .i_phy_wr      (i_phy_wr),
      .i_picked      (w_picked[e]),
      .i_ex1_valid   (i_ex1_valid),
      .i_ex1_update  (i_ex1_update),
      .i_ex2_valid   (i_ex2_valid),
      .i_ex2_update  (i_ex2_update),
      .i_tlb_resolve (i_tlb_resolve),
      .i_lrq_resolve (i_lrq_resolve),
      .i_stq_resolve (i_stq_resolve),
      .i_commit      (i_commit),
      .i_flush       (i_flush),
      .o_entry       (w_entries[e]),
      .o_ready       (w_ready[e]),
      .o_finish      (w_finish[e])
    );
  end

  ldq_ptr_ctrl u_ptr_ctrl (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp_valid (i_disp_valid),
    .i_finish     (w_finish),
    .i_flush      (i_flush),
    .o_tail       (w_tail),
    .o_head       (w_head),
    .o_disp_ready (o_disp_ready)
  );

  ldq_issue_sel u_issue_sel (
    .i_ready       (w_ready),
    .i_head        (w_head),
    .i_entries     (w_entries),
    .o_picked      (w_picked),
    .o_issue_valid (o_issue_valid),
    .o_issue       (o_issue)
  );

endmodule

//--- src/ldq_issue_sel.sv
`include "ldq_cfg.svh"

module ldq_issue_sel (
  input  logic                    i_ready [`LDQ_SIZE],
  input  logic [`LDQ_IDX_W-1:0]   i_head,
  input  ldq_lsu_pkg::ldq_entry_t i_entries [`LDQ_SIZE],
  output logic [`LDQ_SIZE-1:0]    o_picked,
  output logic                    o_issue_valid,
  output ldq_lsu_pkg::issue_t     o_issue
);

  logic [`LDQ_SIZE-1:0]  w_ready;
  logic [`LDQ_SIZE-1:0]  w_ready_rot;
  logic [`LDQ_IDX_W-1:0] w_pos;
  logic [`LDQ_IDX_W-1:0] w_win;
  logic                  w_found;

  always_comb begin
    for (int i = 0; i < `LDQ_SIZE; i++) begin
      w_ready[i]     = i_ready[i];
      w_ready_rot[i] = i_ready[(i + int'(i_head)) % `LDQ_SIZE];
    end
  end

  // lowest rotated bit is the oldest ready load
  always_comb begin
    w_found = 1'b0;
    w_pos   = '0;
    for (int i = 0; i < `LDQ_SIZE; i++) begin
      if (w_ready_rot[i] && !w_found) begin
        w_found = 1'b1;
        w_pos   = i[`LDQ_IDX_W-1:0];
      end
    end
  end

  assign w_win = w_pos + i_head;  // rotate back with wraparound

  assign o_issue_valid  = |w_ready;
  assign o_picked       = o_issue_valid ? (`LDQ_SIZE'(1) << w_win) : '0;
  assign o_issue.index  = w_win;
  assign o_issue.cmt_id = i_entries[w_win].inst.cmt_id;

endmodule

//--- src/ldq_ptr_ctrl.sv
`include "ldq_cfg.svh"

module ldq_ptr_ctrl (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_disp_valid,
  input  logic [`LDQ_SIZE-1:0]  i_finish,
  input  logic                  i_flush,
  output logic [`LDQ_IDX_W-1:0] o_tail,
  output logic [`LDQ_IDX_W-1:0] o_head,
  output logic                  o_disp_ready
);

  logic [`LDQ_IDX_W-1:0] r_tail;
  logic [`LDQ_IDX_W-1:0] r_head;
  logic [`LDQ_IDX_W:0]   r_count;
  logic [`LDQ_IDX_W:0]   w_finish_cnt;
  logic [`LDQ_SIZE-1:0]  w_finish_rot;

  always_comb begin
    w_finish_cnt = '0;
    for (int i = 0; i < `LDQ_SIZE; i++) begin
      w_finish_cnt = w_finish_cnt + i_finish[i];
      w_finish_rot[i] = i_finish[(i + int'(r_head)) % `LDQ_SIZE];  // head aligned to bit 0
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_tail  <= '0;
      r_head  <= '0;
      r_count <= '0;
    end else if (i_flush) begin
      r_tail  <= '0;
      r_head  <= '0;
      r_count <= '0;
    end else begin
      r_tail  <= r_tail + i_disp_valid;
      r_head  <= r_head + w_finish_cnt[`LDQ_IDX_W-1:0];  // in-order free
      r_count <= r_count + i_disp_valid - w_finish_cnt;
    end
  end

  assign o_tail       = r_tail;
  assign o_head       = r_head;
  assign o_disp_ready = (r_count != `LDQ_SIZE);

  a_no_disp_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_disp_valid |-> o_disp_ready);

  // finishing entries form one run starting at the head
  a_finish_from_head: assert property (@(posedge i_clk) disable iff (!i_reset_n || i_flush)
    (w_finish_rot & (w_finish_rot + 1'b1)) == '0);

endmodule

//--- src/ldq_entry.sv
`include "ldq_cfg.svh"

module ldq_entry #(
  parameter int ENTRY_IDX = 0
) (
  input  logic                       i_clk,
  input  logic                       i_reset_n,

  input  logic                       i_load,
  input  ldq_core_pkg::disp_t        i_disp,
  input  ldq_core_pkg::phy_wr_t      i_phy_wr [`WB_BUS_SIZE],

  input  logic                       i_picked,

  input  logic                       i_ex1_valid,
  input  ldq_lsu_pkg::ex1_update_t   i_ex1_update,
  input  logic                       i_ex2_valid,
  input  ldq_lsu_pkg::ex2_update_t   i_ex2_update,

  input  logic                       i_tlb_resolve,
  input  ldq_lsu_pkg::lrq_resolve_t  i_lrq_resolve,
  input  ldq_lsu_pkg::stq_resolve_t  i_stq_resolve,

  input  ldq_core_pkg::commit_t      i_commit,
  input  logic                       i_flush,

  output ldq_lsu_pkg::ldq_entry_t    o_entry,
  output logic                       o_ready,
  output logic                       o_finish
);

  ldq_lsu_pkg::ldq_entry_t r_entry;
  ldq_lsu_pkg::ldq_entry_t w_entry_next;

  logic                 w_rs1_valid;
  logic                 w_rs2_valid;
  logic [`RNID_W-1:0]   w_rs1_rnid;
  logic [`RNID_W-1:0]   w_rs2_rnid;
  logic                 w_rs1_hit;
  logic                 w_rs2_hit;

  logic                 w_ex1_hit;
  logic                 w_ex2_hit;
  logic                 w_lrq_is_hazard;
  logic                 w_lrq_resolve_match;
  logic                 w_lrq_slot_free;
  logic                 w_complete;
  logic [`STQ_SIZE-1:0] w_stq_haz_next;

  // dispatch fields are the ones to watch during the load cycle
  assign w_rs1_valid = i_load ? i_disp.rs1_valid : r_entry.inst.rs1_valid;
  assign w_rs2_valid = i_load ? i_disp.rs2_valid : r_entry.inst.rs2_valid;
  assign w_rs1_rnid  = i_load ? i_disp.rs1_rnid  : r_entry.inst.rs1_rnid;
  assign w_rs2_rnid  = i_load ? i_disp.rs2_rnid  : r_entry.inst.rs2_rnid;

  ldq_wakeup_match u_rs1_match (
    .i_valid  (w_rs1_valid),
    .i_rnid   (w_rs1_rnid),
    .i_phy_wr (i_phy_wr),
    .o_hit    (w_rs1_hit)
  );

  ldq_wakeup_match u_rs2_match (
    .i_valid  (w_rs2_valid),
    .i_rnid   (w_rs2_rnid),
    .i_phy_wr (i_phy_wr),
    .o_hit    (w_rs2_hit)
  );

  assign w_ex1_hit = i_ex1_valid & (i_ex1_update.index == ENTRY_IDX);
  assign w_ex2_hit = i_ex2_valid & (i_ex2_update.index == ENTRY_IDX);

  assign w_lrq_is_hazard = (i_ex2_update.hazard_typ == ldq_lsu_pkg::HAZ_LRQ_CONFLICT) |
                           (i_ex2_update.hazard_typ == ldq_lsu_pkg::HAZ_LRQ_FULL);
  // conflicting slot already drained this cycle
  assign w_lrq_resolve_match = (i_ex2_update.hazard_typ == ldq_lsu_pkg::HAZ_LRQ_CONFLICT) &
                               i_lrq_resolve.valid &
                               (i_lrq_resolve.resolve_oh == i_ex2_update.lrq_index_oh);
  // a full lrq carries no slot, so any resolve frees room
  assign w_lrq_slot_free = i_lrq_resolve.valid &
                           ((r_entry.lrq_haz_oh == '0) |
                            (i_lrq_resolve.resolve_oh == r_entry.lrq_haz_oh));

  assign w_stq_haz_next = i_stq_resolve.valid ?
                          (r_entry.stq_haz_oh & ~i_stq_resolve.resolve_oh) :
                          r_entry.stq_haz_oh;

  assign w_complete = i_commit.commit & (i_commit.cmt_id == r_entry.inst.cmt_id);

  assign o_entry  = r_entry;
  assign o_ready  = (r_entry.state == ldq_lsu_pkg::LDQ_ISSUE_WAIT) &
                    all_operand_ready(r_entry.inst);
  assign o_finish = (r_entry.state == ldq_lsu_pkg::LDQ_WAIT_COMPLETE) & w_complete;

  always_comb begin
    w_entry_next = r_entry;
    w_entry_next.inst.rs1_ready = r_entry.inst.rs1_ready | w_rs1_hit;
    w_entry_next.inst.rs2_ready = r_entry.inst.rs2_ready | w_rs2_hit;

    case (r_entry.state)
      ldq_lsu_pkg::LDQ_INIT: begin
        if (i_load) begin
          w_entry_next.is_valid       = 1'b1;
          w_entry_next.state          = ldq_lsu_pkg::LDQ_ISSUE_WAIT;
          w_entry_next.inst           = i_disp;
          w_entry_next.inst.rs1_ready = i_disp.rs1_ready | w_rs1_hit;
          w_entry_next.inst.rs2_ready = i_disp.rs2_ready | w_rs2_hit;
          w_entry_next.paddr          = '0;
          w_entry_next.except_valid   = 1'b0;
          w_entry_next.lrq_haz_oh     = '0;
          w_entry_next.stq_haz_oh     = '0;
        end
      end
      ldq_lsu_pkg::LDQ_ISSUE_WAIT: begin
        if (o_ready & i_picked) begin
          w_entry_next.state = ldq_lsu_pkg::LDQ_ISSUED;
        end
      end
      ldq_lsu_pkg::LDQ_ISSUED: begin
        if (w_ex1_hit) begin
          w_entry_next.state        = i_ex1_update.tlb_hazard ? ldq_lsu_pkg::LDQ_TLB_HAZ :
                                                                ldq_lsu_pkg::LDQ_EX2_RUN;
          w_entry_next.except_valid = i_ex1_update.tlb_except;
          w_entry_next.paddr        = i_ex1_update.paddr;
        end
      end
      ldq_lsu_pkg::LDQ_TLB_HAZ: begin
        if (i_tlb_resolve) begin
          w_entry_next.state = ldq_lsu_pkg::LDQ_ISSUE_WAIT;
        end
      end
      ldq_lsu_pkg::LDQ_EX2_RUN: begin
        if (w_ex2_hit) begin
          w_entry_next.lrq_haz_oh = i_ex2_update.lrq_index_oh;
          w_entry_next.stq_haz_oh = i_ex2_update.stq_haz_oh;
          if (w_lrq_resolve_match) begin
            w_entry_next.state = ldq_lsu_pkg::LDQ_ISSUE_WAIT;
          end else if (w_lrq_is_hazard) begin
            w_entry_next.state = ldq_lsu_pkg::LDQ_LRQ_HAZ;
          end else if (i_ex2_update.hazard_typ == ldq_lsu_pkg::HAZ_STQ_DEPEND) begin
            w_entry_next.state = ldq_lsu_pkg::LDQ_STQ_HAZ;
          end else if (i_ex2_update.hazard_typ == ldq_lsu_pkg::HAZ_L1D_CONFLICT ||
                       i_ex2_update.hazard_typ == ldq_lsu_pkg::HAZ_LRQ_ASSIGNED) begin
            w_entry_next.state = ldq_lsu_pkg::LDQ_ISSUE_WAIT;  // rerun to pick up the slot
          end else begin
            w_entry_next.state = ldq_lsu_pkg::LDQ_EX3_DONE;
          end
        end
      end
      ldq_lsu_pkg::LDQ_LRQ_HAZ: begin
        if (w_lrq_slot_free) begin
          w_entry_next.state = ldq_lsu_pkg::LDQ_ISSUE_WAIT;
        end
      end
      ldq_lsu_pkg::LDQ_STQ_HAZ: begin
        w_entry_next.stq_haz_oh = w_stq_haz_next;
        if (w_stq_haz_next == '0) begin
          w_entry_next.state = ldq_lsu_pkg::LDQ_ISSUE_WAIT;
        end
      end
      ldq_lsu_pkg::LDQ_EX3_DONE: begin
        w_entry_next.state = ldq_lsu_pkg::LDQ_WAIT_COMPLETE;
      end
      ldq_lsu_pkg::LDQ_WAIT_COMPLETE: begin
        if (w_complete) begin
          w_entry_next.is_valid = 1'b0;
          w_entry_next.state    = ldq_lsu_pkg::LDQ_INIT;
        end
      end
      default: begin
        w_entry_next.state = ldq_lsu_pkg::LDQ_INIT;
      end
    endcase

    // flush wins over everything above
    if (i_flush) begin
      w_entry_next.is_valid = 1'b0;
      w_entry_next.state    = ldq_lsu_pkg::LDQ_INIT;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_entry.is_valid <= 1'b0;
      r_entry.state    <= ldq_lsu_pkg::LDQ_INIT;
    end else begin
      r_entry <= w_entry_next;
    end
  end

  function automatic logic all_operand_ready(ldq_core_pkg::disp_t inst);
    return (!inst.rs1_valid | inst.rs1_ready) & (!inst.rs2_valid | inst.rs2_ready);
  endfunction

  a_ex1_only_issued: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_ex1_hit |-> r_entry.state == ldq_lsu_pkg::LDQ_ISSUED);

  a_lrq_haz_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_ex2_hit & w_lrq_is_hazard |-> $onehot0(i_ex2_update.lrq_index_oh));

  a_lrq_assigned_zero: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_ex2_hit & (i_ex2_update.hazard_typ == ldq_lsu_pkg::HAZ_LRQ_ASSIGNED)
    |-> i_ex2_update.lrq_index_oh == '0);

  // selector must only pick entries that asked
  a_picked_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_picked |-> o_ready);

endmodule

//--- src/ldq_wakeup_match.sv
`include "ldq_cfg.svh"

module ldq_wakeup_match (
  input  logic                  i_valid,
  input  logic [`RNID_W-1:0]    i_rnid,
  input  ldq_core_pkg::phy_wr_t i_phy_wr [`WB_BUS_SIZE],
  output logic                  o_hit
);

  logic [`WB_BUS_SIZE-1:0] w_port_hit;

  always_comb begin
    for (int p = 0; p < `WB_BUS_SIZE; p++) begin
      w_port_hit[p] = i_phy_wr[p].valid & (i_phy_wr[p].rd_rnid == i_rnid);
    end
  end

  // unused sources never wake up
  assign o_hit = i_valid & (|w_port_hit);

endmodule

//--- src/ldq_lsu_pkg.sv
`include "ldq_cfg.svh"

package ldq_lsu_pkg;

  typedef enum logic [3:0] {
    LDQ_INIT          = 4'd0,
    LDQ_ISSUE_WAIT    = 4'd1,
    LDQ_ISSUED        = 4'd2,
    LDQ_TLB_HAZ       = 4'd3,
    LDQ_EX2_RUN       = 4'd4,
    LDQ_LRQ_HAZ       = 4'd5,
    LDQ_STQ_HAZ       = 4'd6,
    LDQ_EX3_DONE      = 4'd7,
    LDQ_WAIT_COMPLETE = 4'd8
  } ldq_state_t;

  // ex2 outcome as reported by the lsu pipe
  typedef enum logic [2:0] {
    HAZ_NONE         = 3'd0,
    HAZ_L1D_CONFLICT = 3'd1,
    HAZ_LRQ_CONFLICT = 3'd2,
    HAZ_LRQ_FULL     = 3'd3,
    HAZ_LRQ_ASSIGNED = 3'd4,
    HAZ_STQ_DEPEND   = 3'd5
  } hazard_t;

  typedef struct packed {
    logic                   is_valid;
    ldq_state_t             state;
    ldq_core_pkg::disp_t    inst;
    logic [`PADDR_W-1:0]    paddr;
    logic                   except_valid;
    logic [`LRQ_SIZE-1:0]   lrq_haz_oh;
    logic [`STQ_SIZE-1:0]   stq_haz_oh;
  } ldq_entry_t;

  typedef struct packed {
    logic [`LDQ_IDX_W-1:0] index;
    logic                  tlb_hazard;
    logic                  tlb_except;
    logic [`PADDR_W-1:0]   paddr;
  } ex1_update_t;

  typedef struct packed {
    logic [`LDQ_IDX_W-1:0] index;
    hazard_t               hazard_typ;
    logic [`LRQ_SIZE-1:0]  lrq_index_oh;
    logic [`STQ_SIZE-1:0]  stq_haz_oh;
  } ex2_update_t;

  typedef struct packed {
    logic                 valid;
    logic [`LRQ_SIZE-1:0] resolve_oh;
  } lrq_resolve_t;

  typedef struct packed {
    logic                 valid;
    logic [`STQ_SIZE-1:0] resolve_oh;
  } stq_resolve_t;

  typedef struct packed {
    logic [`LDQ_IDX_W-1:0] index;
    logic [`CMT_ID_W-1:0]  cmt_id;
  } issue_t;

endpackage

//--- src/ldq_core_pkg.sv
`include "ldq_cfg.svh"

package ldq_core_pkg;

  // load leaving dispatch in program order
  typedef struct packed {
    logic [`CMT_ID_W-1:0] cmt_id;
    logic                 rs1_valid;
    logic [`RNID_W-1:0]   rs1_rnid;
    logic                 rs1_ready;
    logic                 rs2_valid;
    logic [`RNID_W-1:0]   rs2_rnid;
    logic                 rs2_ready;
  } disp_t;

  // writeback port whose valid is a single-cycle pulse
  typedef struct packed {
    logic               valid;
    logic [`RNID_W-1:0] rd_rnid;
  } phy_wr_t;

  typedef struct packed {
    logic                 commit;  // in-order commit strobe
    logic [`CMT_ID_W-1:0] cmt_id;
  } commit_t;

endpackage

//--- include/ldq_cfg.svh
`ifndef LDQ_CFG_SVH
`define LDQ_CFG_SVH

// queue geometry
`define LDQ_SIZE     4
`define LDQ_IDX_W    2

// core side ids
`define CMT_ID_W     6
`define RNID_W       5
`define PADDR_W      16
`define WB_BUS_SIZE  2

// memory side slots
`define LRQ_SIZE     4
`define STQ_SIZE     4

`endif
